// File: rtl/alu_config.svh
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// number of 4-bit lookahead slices in the chain
`define ALU_SLICES 4

// full datapath width, four bits per slice
`define ALU_WIDTH (4 * `ALU_SLICES)

`endif

// File: rtl/alu_pkg.sv
package alu_pkg;

    // command view of the control word, top bit is carry_in
    typedef enum logic [4:0] {
        ADD   = 5'b00000,  // also shift left when a equals b
        SUB   = 5'b11000,  // a + ~b + 1
        XOR   = 5'b00100,
        XNOR  = 5'b01100,  // not of a when b is zero
        COMP  = 5'b01000,  // a + ~b, carry set means a > b when a != b
        AND   = 5'b00101,
        OR    = 5'b00110,
        RSHFT = 5'b00111   // b moves one bit right, a unused
    } alu_cmd;

    // raw view of the same five bits
    typedef struct packed {
        logic       carry_in;       // carry into bit 0, also shift fill of the top bit
        logic       b_inv;          // invert operand b
        logic       carry_disable;  // keep carries out of the result bit
        logic [1:0] cmd;            // result mux select
    } alu_ctrl_internal;

    // control register contents, decoded both ways
    typedef union packed {
        alu_cmd           cmd;
        alu_ctrl_internal ctrl;
    } alu_ctrl;

    // result mux select values
    localparam logic [1:0] MUX_XOR    = 2'd0;  // propagate and not generate
    localparam logic [1:0] MUX_GEN    = 2'd1;
    localparam logic [1:0] MUX_PROP   = 2'd2;
    localparam logic [1:0] MUX_DIRECT = 2'd3;

    // register block addresses, address 3 is unused
    localparam logic [1:0] REG_A    = 2'd0;
    localparam logic [1:0] REG_B    = 2'd1;
    localparam logic [1:0] REG_CTRL = 2'd2;

endpackage

// File: rtl/full_adder.sv
`timescale 1ns/10ps

module full_adder (
    input  logic                      data1,
    input  logic                      data2,
    input  logic                      carry_in,
    input  logic                      direct_in,  // neighbour bit for the shift path
    input  alu_pkg::alu_ctrl_internal ctrl,
    output logic                      ret,
    output logic                      gen,
    output logic                      propagate,
    output logic                      d2_inv
);

    logic carry_gated;
    logic half_sum;
    logic mux_out;

    assign d2_inv      = data2 ^ ctrl.b_inv;
    assign gen         = data1 & d2_inv;
    assign propagate   = data1 | d2_inv;
    assign half_sum    = propagate & ~gen;  // a xor b built from the lookahead terms
    assign carry_gated = carry_in & ~ctrl.carry_disable;

    always_comb begin
        case (ctrl.cmd)
            alu_pkg::MUX_XOR:    mux_out = half_sum;
            alu_pkg::MUX_GEN:    mux_out = gen;
            alu_pkg::MUX_PROP:   mux_out = propagate;
            alu_pkg::MUX_DIRECT: mux_out = direct_in;
        endcase
    end

    // logic commands set carry_disable so this passes the mux value unchanged
    assign ret = mux_out ^ carry_gated;

endmodule

// File: rtl/alu_slice.sv
`timescale 1ns/10ps

module alu_slice (
    input  logic [3:0]                d1,
    input  logic [3:0]                d2,
    input  logic                      carry_in,
    input  logic                      shift_in,   // d2 bit 0 of the slice above
    input  alu_pkg::alu_ctrl_internal ctrl,
    output logic [3:0]                res,
    output logic                      carry_out,
    output logic                      d2_low      // to the slice below
);

    logic [3:0] gen;
    logic [3:0] propagate;
    logic [3:0] d2_inv;
    logic [3:0] direct;
    logic [4:0] carry;

    // each bit takes the next bit up, the top one the neighbour slice
    assign direct = {shift_in, d2_inv[3:1]};

    for (genvar i = 0; i < 4; i++) begin : g_bit
        full_adder i_fa (
            .data1     (d1[i]),
            .data2     (d2[i]),
            .carry_in  (carry[i]),
            .direct_in (direct[i]),
            .ctrl      (ctrl),
            .ret       (res[i]),
            .gen       (gen[i]),
            .propagate (propagate[i]),
            .d2_inv    (d2_inv[i])
        );
    end

    assign carry[0] = carry_in;

    // every carry is a flat and-or of generate, propagate and carry_in
    assign carry[1] = gen[0]
                    | (propagate[0] & carry_in);

    assign carry[2] = gen[1]
                    | (propagate[1] & gen[0])
                    | (propagate[1] & propagate[0] & carry_in);

    assign carry[3] = gen[2]
                    | (propagate[2] & gen[1])
                    | (propagate[2] & propagate[1] & gen[0])
                    | (propagate[2] & propagate[1] & propagate[0] & carry_in);

    assign carry[4] = gen[3]
                    | (propagate[3] & gen[2])
                    | (propagate[3] & propagate[2] & gen[1])
                    | (propagate[3] & propagate[2] & propagate[1] & gen[0])
                    | (propagate[3] & propagate[2] & propagate[1] & propagate[0] & carry_in);

    assign carry_out = carry[4];
    assign d2_low    = d2_inv[0];

endmodule

// File: rtl/alu_chain.sv
`timescale 1ns/10ps
`include "alu_config.svh"

module alu_chain (
    input  logic [`ALU_WIDTH-1:0] op_a,
    input  logic [`ALU_WIDTH-1:0] op_b,
    input  alu_pkg::alu_ctrl      ctrl,
    output logic [`ALU_WIDTH-1:0] result,
    output logic                  carry_out
);

    localparam int SLICES = `ALU_SLICES;

    logic [SLICES:0]   carry;     // ripple between slices
    logic [SLICES-1:0] shift_in;
    logic [SLICES-1:0] d2_low;
    logic              fill_bit;

    // carry_in doubles as the fill of a right shift
    assign fill_bit = ctrl.ctrl.carry_in;
    assign carry[0] = ctrl.ctrl.carry_in;

    for (genvar s = 0; s < SLICES; s++) begin : g_slice
        if (s == SLICES - 1) begin : g_top
            assign shift_in[s] = fill_bit;
        end else begin : g_mid
            assign shift_in[s] = d2_low[s+1];  // lowest d2 bit of the slice above
        end

        alu_slice i_slice (
            .d1        (op_a[4*s +: 4]),
            .d2        (op_b[4*s +: 4]),
            .carry_in  (carry[s]),
            .shift_in  (shift_in[s]),
            .ctrl      (ctrl.ctrl),
            .res       (result[4*s +: 4]),
            .carry_out (carry[s+1]),
            .d2_low    (d2_low[s])
        );
    end

    assign carry_out = carry[SLICES];

endmodule

// File: rtl/alu_regs.sv
`timescale 1ns/10ps
`include "alu_config.svh"

module alu_regs (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  wr_en,
    input  logic [1:0]            wr_addr,
    input  logic [`ALU_WIDTH-1:0] wr_data,
    output logic [`ALU_WIDTH-1:0] op_a,
    output logic [`ALU_WIDTH-1:0] op_b,
    output alu_pkg::alu_ctrl      ctrl
);

    logic sel_a;
    logic sel_b;
    logic sel_ctrl;

    // one register per address, address 3 selects nothing
    assign sel_a    = wr_en && (wr_addr == alu_pkg::REG_A);
    assign sel_b    = wr_en && (wr_addr == alu_pkg::REG_B);
    assign sel_ctrl = wr_en && (wr_addr == alu_pkg::REG_CTRL);

    always_ff @(posedge clk) begin
        if (reset) begin
            op_a <= '0;
        end else if (sel_a) begin
            op_a <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            op_b <= '0;
        end else if (sel_b) begin
            op_b <= wr_data;
        end
    end

    // zero decodes as ADD, raw bit patterns are kept as written
    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl <= '0;
        end else if (sel_ctrl) begin
            ctrl <= wr_data[4:0];  // low five bits only
        end
    end

endmodule

// File: rtl/alu_status.sv
`timescale 1ns/10ps
`include "alu_config.svh"

module alu_status (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  go,
    input  logic [`ALU_WIDTH-1:0] result,
    input  logic                  carry_out,
    output logic [`ALU_WIDTH-1:0] res,
    output logic                  carry_flag,
    output logic                  zero_flag,
    output logic                  negative_flag,
    output logic                  valid
);

    logic result_zero;
    logic result_sign;

    assign result_zero = (result == '0);
    assign result_sign = result[`ALU_WIDTH-1];

    // outputs hold between go pulses
    always_ff @(posedge clk) begin
        if (reset) begin
            res           <= '0;
            carry_flag    <= 1'b0;
            zero_flag     <= 1'b0;
            negative_flag <= 1'b0;
        end else if (go) begin
            res           <= result;
            carry_flag    <= carry_out;  // raw lookahead carry, not inverted for SUB
            zero_flag     <= result_zero;
            negative_flag <= result_sign;
        end
    end

    // one valid cycle per go
    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else begin
            valid <= go;
        end
    end

endmodule

// File: rtl/alu_unit.sv
`timescale 1ns/10ps
`include "alu_config.svh"

module alu_unit (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  wr_en,
    input  logic [1:0]            wr_addr,
    input  logic [`ALU_WIDTH-1:0] wr_data,
    input  logic                  go,
    output logic [`ALU_WIDTH-1:0] res,
    output logic                  carry_flag,
    output logic                  zero_flag,
    output logic                  negative_flag,
    output logic                  valid
);

    logic [`ALU_WIDTH-1:0] op_a;
    logic [`ALU_WIDTH-1:0] op_b;
    alu_pkg::alu_ctrl      ctrl;
    logic [`ALU_WIDTH-1:0] result;  // combinational from the registers
    logic                  carry_out;

    alu_regs i_regs (
        .clk     (clk),
        .reset   (reset),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .op_a    (op_a),
        .op_b    (op_b),
        .ctrl    (ctrl)
    );

    alu_chain i_chain (
        .op_a      (op_a),
        .op_b      (op_b),
        .ctrl      (ctrl),
        .result    (result),
        .carry_out (carry_out)
    );

    alu_status i_status (
        .clk           (clk),
        .reset         (reset),
        .go            (go),
        .result        (result),
        .carry_out     (carry_out),
        .res           (res),
        .carry_flag    (carry_flag),
        .zero_flag     (zero_flag),
        .negative_flag (negative_flag),
        .valid         (valid)
    );

endmodule

// File: sim/alu_unit_tb.sv
`timescale 1ns/10ps
`include "alu_config.svh"

module alu_unit_tb;

    localparam int W           = `ALU_WIDTH;
    localparam int RANDOM_OPS  = 560;
    localparam int CYCLE_LIMIT = 5000;  // about 600 operations of 5 cycles plus margin

    localparam logic [4:0] ADD_CARRY  = 5'b10000;  // add with carry_in set
    localparam logic [4:0] RSHFT_FILL = 5'b10111;  // right shift with a fill of 1

    typedef logic [W-1:0] word_t;
    typedef logic [W:0]   wide_t;

    logic       clk;
    logic       reset;
    logic       wr_en;
    logic [1:0] wr_addr;
    word_t      wr_data;
    logic       go;
    word_t      res;
    logic       carry_flag;
    logic       zero_flag;
    logic       negative_flag;
    logic       valid;

    // copy of the DUT register block
    word_t      shadow_a;
    word_t      shadow_b;
    logic [4:0] shadow_ctrl;

    word_t exp_res_q[$];
    logic  exp_carry_q[$];
    bit    carry_known_q[$];  // carry is only defined for the arithmetic commands

    logic go_sampled;
    int   error_count;
    int   check_count;
    int   cycle_count;

    alu_unit i_dut (
        .clk           (clk),
        .reset         (reset),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .go            (go),
        .res           (res),
        .carry_flag    (carry_flag),
        .zero_flag     (zero_flag),
        .negative_flag (negative_flag),
        .valid         (valid)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    function automatic void predict_result(input word_t a, input word_t b,
                                           input logic [4:0] ctrl, output word_t r,
                                           output logic c, output bit c_known);
        wide_t wide;
        wide    = '0;
        r       = '0;
        c       = 1'b0;
        c_known = 1'b0;
        case (ctrl)
            alu_pkg::ADD, ADD_CARRY: begin
                wide    = wide_t'(a) + wide_t'(b) + wide_t'(ctrl[4]);
                r       = wide[W-1:0];
                c       = wide[W];
                c_known = 1'b1;
            end
            alu_pkg::SUB: begin
                r       = a - b;
                c       = (b <= a);  // no borrow
                c_known = 1'b1;
            end
            alu_pkg::COMP: begin
                r       = a - b - word_t'(1);
                c       = (a > b);
                c_known = (a != b);
            end
            alu_pkg::XOR:   r = a ^ b;
            alu_pkg::XNOR:  r = ~(a ^ b);
            alu_pkg::AND:   r = a & b;
            alu_pkg::OR:    r = a | b;
            alu_pkg::RSHFT: r = {1'b0, b[W-1:1]};
            RSHFT_FILL:     r = {1'b1, b[W-1:1]};
            default: ;
        endcase
    endfunction

    function automatic logic [4:0] ctrl_for_index(input int unsigned idx);
        case (idx)
            0:       return alu_pkg::ADD;
            1:       return alu_pkg::SUB;
            2:       return alu_pkg::XOR;
            3:       return alu_pkg::XNOR;
            4:       return alu_pkg::COMP;
            5:       return alu_pkg::AND;
            6:       return alu_pkg::OR;
            7:       return alu_pkg::RSHFT;
            8:       return ADD_CARRY;
            default: return RSHFT_FILL;
        endcase
    endfunction

    task automatic update_shadow(input logic [1:0] addr, input word_t data);
        case (addr)
            alu_pkg::REG_A:    shadow_a    = data;
            alu_pkg::REG_B:    shadow_b    = data;
            alu_pkg::REG_CTRL: shadow_ctrl = data[4:0];
            default: ;  // address 3 holds nothing
        endcase
    endtask

    task automatic queue_expected();
        word_t r;
        logic  c;
        bit    k;
        predict_result(shadow_a, shadow_b, shadow_ctrl, r, c, k);
        exp_res_q.push_back(r);
        exp_carry_q.push_back(c);
        carry_known_q.push_back(k);
    endtask

    // all stimulus tasks start and end on a falling edge
    task automatic write_reg(input logic [1:0] addr, input word_t data);
        wr_en   = 1'b1;
        wr_addr = addr;
        wr_data = data;
        @(negedge clk);
        wr_en = 1'b0;
        update_shadow(addr, data);
    endtask

    task automatic pulse_go();
        queue_expected();
        go = 1'b1;
        @(negedge clk);
        go = 1'b0;
    endtask

    task automatic go_with_write(input logic [1:0] addr, input word_t data);
        queue_expected();  // register values from before the write
        go      = 1'b1;
        wr_en   = 1'b1;
        wr_addr = addr;
        wr_data = data;
        @(negedge clk);
        go    = 1'b0;
        wr_en = 1'b0;
        update_shadow(addr, data);
    endtask

    task automatic wait_results();
        while (exp_res_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic run_op(input word_t a, input word_t b, input logic [4:0] ctrl);
        write_reg(alu_pkg::REG_A, a);
        write_reg(alu_pkg::REG_B, b);
        write_reg(alu_pkg::REG_CTRL, word_t'(ctrl));
        pulse_go();
        wait_results();
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        assert (actual == expected) else begin
            $display("Error %s expected %h got %h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        assert (actual === expected) else begin
            $display("Error %s expected %h got %h", name, expected, actual);
            error_count++;
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            go_sampled <= 1'b0;
        end else begin
            go_sampled <= go;
        end
    end

    // outputs are compared on the falling edge, half a cycle after they change
    always @(negedge clk) begin
        word_t exp_res;
        logic  exp_carry;
        bit    carry_known;
        if (!reset) begin
            if (go_sampled) begin
                exp_res     = exp_res_q.pop_front();
                exp_carry   = exp_carry_q.pop_front();
                carry_known = carry_known_q.pop_front();
                check_count++;
                assert (valid) else begin
                    $display("no valid pulse in the cycle after go");
                    error_count++;
                end
                check_word("res", exp_res, res);
                if (carry_known) begin
                    check_bit("carry_flag", exp_carry, carry_flag);
                end
                check_bit("zero_flag", (exp_res == '0), zero_flag);
                check_bit("negative_flag", exp_res[W-1], negative_flag);
            end else begin
                check_bit("valid", 1'b0, valid);
                if (check_count == 0) begin  // nothing computed since reset
                    check_word("res", '0, res);
                    check_bit("carry_flag", 1'b0, carry_flag);
                    check_bit("zero_flag", 1'b0, zero_flag);
                    check_bit("negative_flag", 1'b0, negative_flag);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("simulation still running after %0d cycles, stopped", cycle_count);
            $display("test failed");
            $finish;
        end
    end

    initial begin
        word_t      a;
        word_t      b;
        logic [4:0] ctrl;
        int         pending;
        void'($urandom(92503));
        error_count = 0;
        check_count = 0;
        cycle_count = 0;
        reset       = 1'b1;
        wr_en       = 1'b0;
        wr_addr     = '0;
        wr_data     = '0;
        go          = 1'b0;
        shadow_a    = '0;
        shadow_b    = '0;
        shadow_ctrl = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        repeat (3) @(negedge clk);

        pulse_go();  // registers out of reset read as ADD of zeros
        wait_results();

        run_op('1, word_t'(1), alu_pkg::ADD);
        run_op(word_t'(16'h1234), word_t'(16'h1111), ADD_CARRY);
        run_op(word_t'(16'h5a5a), word_t'(16'h5a5a), alu_pkg::SUB);
        run_op(word_t'(3), word_t'(5), alu_pkg::SUB);
        run_op(word_t'(7), word_t'(3), alu_pkg::COMP);
        run_op(word_t'(3), word_t'(7), alu_pkg::COMP);
        run_op(word_t'(16'hc3c3), word_t'(16'hc3c3), alu_pkg::XOR);
        run_op(word_t'(16'hf0f0), word_t'(16'h0ff0), alu_pkg::XNOR);
        run_op(word_t'(16'hf0f0), word_t'(16'h0ff0), alu_pkg::AND);
        run_op(word_t'(16'hf0f0), word_t'(16'h0ff0), alu_pkg::OR);
        run_op(word_t'(16'h1234), word_t'(16'h8001), alu_pkg::RSHFT);
        run_op(word_t'(16'h1234), word_t'(16'h0002), RSHFT_FILL);

        // a write to address 3 must leave all registers alone
        run_op(word_t'(16'h00ff), word_t'(16'h0f0f), alu_pkg::XOR);
        write_reg(2'd3, '1);
        pulse_go();
        wait_results();

        // go next to writes, and back-to-back go pulses
        run_op(word_t'(16'h0010), word_t'(16'h0003), alu_pkg::SUB);
        go_with_write(alu_pkg::REG_A, word_t'(16'h0100));
        pulse_go();
        go_with_write(alu_pkg::REG_CTRL, word_t'(alu_pkg::ADD));
        pulse_go();
        wait_results();

        for (int i = 0; i < RANDOM_OPS; i++) begin
            a    = word_t'($urandom);
            b    = ($urandom_range(0, 7) == 0) ? a : word_t'($urandom);
            ctrl = ctrl_for_index($urandom_range(0, 9));
            run_op(a, b, ctrl);
        end

        repeat (2) @(negedge clk);
        pending = exp_res_q.size();
        $display("checked %0d results, %0d errors, %0d results missing",
                 check_count, error_count, pending);
        if (error_count == 0 && pending == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+rtl
rtl/alu_pkg.sv
rtl/full_adder.sv
rtl/alu_slice.sv
rtl/alu_chain.sv
rtl/alu_regs.sv
rtl/alu_status.sv
rtl/alu_unit.sv
sim/alu_unit_tb.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -f verilog.f --top-module alu_unit_tb -o alu_unit_sim \
    && ./obj_dir/alu_unit_sim | tee /dev/stderr | grep -qx "test passed" \
    && echo "simulation ok" && exit 0 \
    || { echo "simulation not ok"; exit 1; }
